// ==== fpuExec.f ====
source/fpuExecPkg.sv
source/issueIf.sv
source/latencyTimer.sv
source/intAluUnit.sv
source/fpSignUnit.sv
source/fpTruncUnit.sv
source/fpScaleUnit.sv
source/execSequencer.sv
source/fpuExecTop.sv
bench/fpuExec_checker.sv
bench/fpuExecTb.sv

// ==== Bender.yml ====
package:
  name: fpuExec

sources:
  - source/fpuExecPkg.sv
  - source/issueIf.sv
  - source/latencyTimer.sv
  - source/intAluUnit.sv
  - source/fpSignUnit.sv
  - source/fpTruncUnit.sv
  - source/fpScaleUnit.sv
  - source/execSequencer.sv
  - source/fpuExecTop.sv
  - target: simulation
    files:
      - bench/fpuExec_checker.sv
      - bench/fpuExecTb.sv

// ==== bench/fpuExecTb.sv ====
// ======================================================================
// Testbench for the execute unit: random instruction streams checked
// against a reference model, with random result back-pressure
// ======================================================================
module fpuExecTb
	import fpuExecPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// Operation counts per test
	localparam int intOps = 200;
	localparam int signOps = 70;
	localparam int truncOps = 48;
	localparam int scaleOps = 48;
	localparam int stallOps = 100;
	localparam int illegalOps = 4;
	localparam int totalOps = intOps + signOps + truncOps + scaleOps + stallOps + illegalOps;
	// Extra cycles one op can lose to the slowest unit and to ready held low
	localparam int maxReadyLow = 4;
	localparam int longestStall = int'(latScale) - int'(latAlu) + maxReadyLow;
	localparam int cycleLimit = totalOps * (4 + longestStall) + 100;

	logic clk;
	logic rst;
	logic opValid;
	logic opReady;
	logic [31:0] instr;
	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic [dataWidth-1:0] imm;
	logic resultValid;
	logic resultReady;
	logic [dataWidth-1:0] result;
	logic illegal;

	integer seed;
	integer stallSeed;
	bit stallOn;
	int lowRun;
	int cycleCount;
	int errorCount;
	int checkCount;
	int issuedCount;
	int receivedCount;
	// Expected {illegal, result} in issue order
	logic [dataWidth:0] expectQ[$];
	logic [dataWidth:0] headExpect;

	opcode_t aluOps[7] = '{OP_ADD, OP_AND, OP_OR, OP_XOR, OP_SUBF, OP_MOV, OP_LOADA};
	fltFunc_t signFuncs[7] = '{FN_FABS, FN_FNEG, FN_SGNJ, FN_SGNJN, FN_SGNJX,
		FN_ISNAN, FN_FINITE};

	fpuExecTop u_fpuExecTop (
		.clk(clk),
		.rst(rst),
		.opValid(opValid),
		.opReady(opReady),
		.instr(instr),
		.a(a),
		.b(b),
		.imm(imm),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.result(result),
		.illegal(illegal)
	);

	bind fpuExecTop fpuExec_checker uChecker (
		.clk(clk),
		.rst(rst),
		.opReady(opReady),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.result(result),
		.illegal(illegal)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==================================================================
	// Stimulus helpers
	// ==================================================================
	function automatic logic [dataWidth-1:0] randWide();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// Random sign and fraction with a chosen biased exponent
	function automatic logic [dataWidth-1:0] quadWithExp(input int biasedExp);
		logic [dataWidth-1:0] q;
		q = randWide();
		q[fracBits +: expBits] = expBits'(biasedExp);
		return q;
	endfunction

	// 0 zero, 1 infinity, 2 NaN, 3 denormal
	function automatic logic [dataWidth-1:0] edgeQuad(input int kind);
		logic [dataWidth-1:0] q;
		q = randWide();
		case (kind)
			0: q[dataWidth-2:0] = '0;
			1: begin
				q[fracBits +: expBits] = '1;
				q[fracBits-1:0] = '0;
			end
			2: begin
				q[fracBits +: expBits] = '1;
				q[fracBits-1] = 1'b1;
			end
			default: q[fracBits +: expBits] = '0;
		endcase
		return q;
	endfunction

	function automatic logic [dataWidth-1:0] randQuad();
		if (($random(seed) & 3) == 0)
			return edgeQuad($unsigned($random(seed)) % 4);
		return quadWithExp(expBias + ($random(seed) % 64));
	endfunction

	// ==================================================================
	// Reference model
	// ==================================================================
	function automatic logic [dataWidth-1:0] bitOp(input opcode_t op,
			input logic [dataWidth-1:0] x, input logic [dataWidth-1:0] y);
		case (op)
			OP_AND: return x & y;
			OP_OR: return x | y;
			default: return x ^ y;
		endcase
	endfunction

	function automatic logic [dataWidth-1:0] truncModel(input logic [dataWidth-1:0] va);
		logic [dataWidth-1:0] y;
		int e;
		int k;
		e = int'(va[fracBits +: expBits]) - expBias;
		y = va;
		if (e < 0)
			y = {va[dataWidth-1], {(dataWidth-1){1'b0}}};
		else if (e < fracBits)
			for (k = 0; k < fracBits - e; k++)
				y[k] = 1'b0;
		return y;
	endfunction

	function automatic logic [dataWidth-1:0] scaleModel(input logic [dataWidth-1:0] va,
			input logic [dataWidth-1:0] vb);
		logic signed [dataWidth-1:0] shiftIn;
		logic [dataWidth-1:0] y;
		int shift;
		int expIn;
		int expOut;
		shiftIn = vb;
		if (shiftIn > scaleLimit)
			shift = scaleLimit;
		else if (shiftIn < -scaleLimit)
			shift = -scaleLimit;
		else
			shift = int'(shiftIn);
		expIn = int'(va[fracBits +: expBits]);
		expOut = expIn + shift;
		y = va;
		if ((expIn == 0) || (expIn == expMax))
			y = va;
		else if (expOut >= expMax)
			y = {va[dataWidth-1], {expBits{1'b1}}, {fracBits{1'b0}}};
		else if (expOut <= 0)
			y = {va[dataWidth-1], {(dataWidth-1){1'b0}}};
		else
			y[fracBits +: expBits] = expBits'(expOut);
		return y;
	endfunction

	// Returns {illegal, result}
	function automatic logic [dataWidth:0] predict(input instrWord_t iw,
			input logic [dataWidth-1:0] va, input logic [dataWidth-1:0] vb,
			input logic [dataWidth-1:0] vi);
		logic [dataWidth-1:0] y;
		logic [dataWidth-1:0] second;
		logic [dataWidth-1:0] sum;
		logic bad;
		y = '0;
		bad = 1'b0;
		second = iw.alu.immSel ? vi : vb;
		sum = va + second;
		case (iw.alu.opcode)
			OP_ADD: begin
				if (iw.alu.op3 == 3'd0)
					y = sum;
				else if (iw.alu.op3 == 3'd2)
					y = sum[dataWidth-1] ? (~sum + 1'b1) : sum;
			end
			OP_AND, OP_OR, OP_XOR: begin
				if (iw.alu.op3 == 3'd0)
					y = bitOp(iw.alu.opcode, va, second);
				else if (iw.alu.op3 == 3'd1)
					y = ~bitOp(iw.alu.opcode, va, second);
				else if (iw.alu.op3 == 3'd2)
					y = bitOp(iw.alu.opcode, va, ~second);
			end
			OP_SUBF: y = second - va;
			OP_MOV: y = va;
			OP_LOADA: y = va + vi + (vb << iw.alu.shAmt);
			OP_FLT: begin
				case (iw.flt.func)
					FN_FABS: y = {1'b0, va[dataWidth-2:0]};
					FN_FNEG: y = {~va[dataWidth-1], va[dataWidth-2:0]};
					FN_SGNJ: y = {va[dataWidth-1], vb[dataWidth-2:0]};
					FN_SGNJN: y = {~va[dataWidth-1], vb[dataWidth-2:0]};
					FN_SGNJX: y = {va[dataWidth-1] ^ vb[dataWidth-1], vb[dataWidth-2:0]};
					FN_ISNAN: y = dataWidth'((va[fracBits +: expBits] == '1) &&
						(va[fracBits-1:0] != '0));
					FN_FINITE: y = dataWidth'(va[fracBits +: expBits] != '1);
					FN_FTRUNC: y = truncModel(va);
					FN_FSCALEB: y = scaleModel(va, vb);
					default: bad = 1'b1;
				endcase
			end
			default: bad = 1'b1;
		endcase
		return {bad, y};
	endfunction

	// ==================================================================
	// Checking and handshakes
	// ==================================================================
	task automatic checkValue(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] expected);
		checkCount++;
		if (got !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	// Entered and left 1 ns after a rising edge once the op is accepted
	task automatic issueOp(input instrWord_t iw, input logic [dataWidth-1:0] va,
			input logic [dataWidth-1:0] vb, input logic [dataWidth-1:0] vi);
		logic taken;
		instr = iw;
		a = va;
		b = vb;
		imm = vi;
		opValid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = opReady;
			@(posedge clk);
			#1;
		end
		expectQ.push_back(predict(iw, va, vb, vi));
		issuedCount++;
		opValid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expectQ.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("Test %-14s finished with %0d errors", name, errorCount - startErrors);
	endtask

	// Result side sampled mid-cycle before the transfer edge
	always @(negedge clk) begin
		if (!rst && resultValid && resultReady) begin
			receivedCount++;
			if (expectQ.size() == 0) begin
				$display("A result arrived with no instruction outstanding");
				errorCount++;
			end else begin
				headExpect = expectQ.pop_front();
				checkValue("result", result, headExpect[dataWidth-1:0]);
				checkValue("illegal", illegal, headExpect[dataWidth]);
			end
		end
	end

	// Random back-pressure with a bounded low run
	always @(posedge clk) begin
		#1;
		if (stallOn && (lowRun < maxReadyLow) && (($random(stallSeed) & 1) != 0)) begin
			resultReady = 1'b0;
			lowRun++;
		end else begin
			resultReady = 1'b1;
			lowRun = 0;
		end
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycleLimit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ==================================================================
	// Tests
	// ==================================================================
	task automatic runIntTest();
		instrWord_t iw;
		int startErrors;
		int i;
		startErrors = errorCount;
		for (i = 0; i < intOps; i++) begin
			iw = instrWord_t'($random(seed));
			// Every opcode and op3 pair with b and again with imm
			iw.alu.opcode = aluOps[i % 7];
			iw.alu.op3 = 3'((i / 7) % 8);
			iw.alu.immSel = 1'((i / 56) % 2);
			issueOp(iw, randWide(), randWide(), randWide());
		end
		waitDrain();
		reportTest("integer", startErrors);
	endtask

	task automatic runSignTest();
		instrWord_t iw;
		int startErrors;
		int i;
		startErrors = errorCount;
		for (i = 0; i < signOps; i++) begin
			iw = instrWord_t'($random(seed));
			iw.flt.opcode = OP_FLT;
			iw.flt.func = signFuncs[i % 7];
			issueOp(iw, randQuad(), randQuad(), randWide());
		end
		waitDrain();
		reportTest("sign", startErrors);
	endtask

	task automatic runTruncTest();
		instrWord_t iw;
		logic [dataWidth-1:0] va;
		int startErrors;
		int i;
		startErrors = errorCount;
		for (i = 0; i < truncOps; i++) begin
			iw = instrWord_t'($random(seed));
			iw.flt.opcode = OP_FLT;
			iw.flt.func = FN_FTRUNC;
			case (i % 4)
				0: va = quadWithExp(expBias - 1 - ($random(seed) & 255));
				1: va = quadWithExp(expBias + ($unsigned($random(seed)) % fracBits));
				2: va = quadWithExp(expBias + fracBits + ($random(seed) & 1023));
				default: va = edgeQuad((i / 4) % 4);
			endcase
			// Boundaries of the middle range
			if (i == 1)
				va = quadWithExp(expBias);
			if (i == 5)
				va = quadWithExp(expBias + fracBits - 1);
			if (i == 2)
				va = quadWithExp(expBias + fracBits);
			issueOp(iw, va, randWide(), randWide());
		end
		waitDrain();
		reportTest("truncate", startErrors);
	endtask

	task automatic runScaleTest();
		instrWord_t iw;
		logic [dataWidth-1:0] va;
		logic [dataWidth-1:0] vb;
		int startErrors;
		int i;
		startErrors = errorCount;
		for (i = 0; i < scaleOps; i++) begin
			iw = instrWord_t'($random(seed));
			iw.flt.opcode = OP_FLT;
			iw.flt.func = FN_FSCALEB;
			va = quadWithExp(expBias + ($random(seed) % 1000));
			vb = $random(seed) % 200;
			case (i % 6)
				1: begin
					vb = randWide();
					vb[dataWidth-1] = 1'b0;
					if (i % 12 == 1)
						vb = 20000 + ($random(seed) & 65535);
				end
				2: begin
					vb = randWide();
					vb[dataWidth-1] = 1'b1;
					if (i % 12 == 2)
						vb = -20000 - ($random(seed) & 255);
				end
				3: va = edgeQuad(((i / 6) % 2 == 0) ? 0 : 3);
				4: va = edgeQuad(1);
				5: va = edgeQuad(2);
				default: ;
			endcase
			issueOp(iw, va, vb, randWide());
		end
		waitDrain();
		reportTest("scale", startErrors);
	endtask

	task automatic runStallTest();
		instrWord_t iw;
		logic [dataWidth-1:0] vb;
		int startErrors;
		int i;
		startErrors = errorCount;
		stallOn = 1'b1;
		for (i = 0; i < stallOps; i++) begin
			iw = instrWord_t'($random(seed));
			vb = randQuad();
			case ($unsigned($random(seed)) % 4)
				0: begin
					iw.alu.opcode = aluOps[$unsigned($random(seed)) % 7];
					vb = randWide();
				end
				1: begin
					iw.flt.opcode = OP_FLT;
					iw.flt.func = signFuncs[$unsigned($random(seed)) % 7];
				end
				2: begin
					iw.flt.opcode = OP_FLT;
					iw.flt.func = FN_FTRUNC;
				end
				default: begin
					iw.flt.opcode = OP_FLT;
					iw.flt.func = FN_FSCALEB;
					vb = $random(seed) % 40000;
				end
			endcase
			issueOp(iw, randQuad(), vb, randWide());
		end
		waitDrain();
		stallOn = 1'b0;
		checkValue("resultCount", receivedCount, issuedCount);
		reportTest("backpressure", startErrors);
	endtask

	task automatic runIllegalTest();
		instrWord_t iw;
		int startErrors;
		startErrors = errorCount;
		iw = instrWord_t'($random(seed));
		iw.flt.opcode = OP_FLT;
		iw.flt.func = fltFunc_t'(7'h7F);
		issueOp(iw, randQuad(), randQuad(), randWide());
		iw.flt.func = fltFunc_t'(7'h00);
		issueOp(iw, randQuad(), randQuad(), randWide());
		// Undefined opcodes run through the ALU
		iw.alu.opcode = opcode_t'(7'h7F);
		issueOp(iw, randWide(), randWide(), randWide());
		iw.alu.opcode = opcode_t'(7'h01);
		issueOp(iw, randWide(), randWide(), randWide());
		waitDrain();
		reportTest("illegal", startErrors);
	endtask

	initial begin
		seed = 32'h8d23;
		stallSeed = 32'h8d23;
		stallOn = 1'b0;
		lowRun = 0;
		errorCount = 0;
		checkCount = 0;
		issuedCount = 0;
		receivedCount = 0;
		rst = 1'b1;
		opValid = 1'b0;
		instr = '0;
		a = '0;
		b = '0;
		imm = '0;
		resultReady = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		checkValue("opReady", opReady, 1);
		checkValue("resultValid", resultValid, 0);
		checkValue("illegal", illegal, 0);
		@(posedge clk);
		#1;

		runIntTest();
		runSignTest();
		runTruncTest();
		runScaleTest();
		runStallTest();
		runIllegalTest();

		errorCount += u_fpuExecTop.uChecker.failCount;
		$display("Summary: %0d checks, %0d errors, %0d issued, %0d results",
			checkCount, errorCount, issuedCount, receivedCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== bench/fpuExec_checker.sv ====
// ======================================================================
// Handshake assertions for the execute unit, bound to its top level
// ======================================================================
module fpuExec_checker
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	input logic opReady,
	input logic resultValid,
	input logic resultReady,
	input logic [dataWidth-1:0] result,
	input logic illegal
);
	timeunit 1ns;
	timeprecision 1ps;

	// Number of assertion failures so far
	int failCount = 0;

	// One instruction in flight, so no issue while a result waits
	noIssueWhileHeld: assert property (@(posedge clk) disable iff (rst)
		resultValid |-> !opReady)
		else begin
			$error("opReady is high while a result is held");
			failCount++;
		end

	// A held result stays put until it is taken
	resultHeld: assert property (@(posedge clk) disable iff (rst)
		(resultValid && !resultReady) |=>
			(resultValid && $stable(result) && $stable(illegal)))
		else begin
			$error("held result changed or was dropped before transfer");
			failCount++;
		end

	illegalWithValid: assert property (@(posedge clk) disable iff (rst)
		illegal |-> resultValid)
		else begin
			$error("illegal is high without resultValid");
			failCount++;
		end

endmodule

// ==== source/fpuExecTop.sv ====
// ======================================================================
// 128-bit execute unit top level with issue and result handshakes
// ======================================================================
module fpuExecTop
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	input logic opValid,
	output logic opReady,
	input logic [31:0] instr,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic [dataWidth-1:0] imm,
	output logic resultValid,
	input logic resultReady,
	output logic [dataWidth-1:0] result,
	output logic illegal
);

	logic expired;
	logic timerLoad;
	logic [timerWidth-1:0] timerCount;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] signResult;
	logic [dataWidth-1:0] truncResult;
	logic [dataWidth-1:0] scaleResult;

	issueIf uIssue ();

	execSequencer uSequencer (
		.clk(clk),
		.rst(rst),
		.opValid(opValid),
		.opReady(opReady),
		.instr(instrWord_t'(instr)),
		.a(a),
		.b(b),
		.imm(imm),
		.resultReady(resultReady),
		.resultValid(resultValid),
		.result(result),
		.illegal(illegal),
		.expired(expired),
		.timerLoad(timerLoad),
		.timerCount(timerCount),
		.aluResult(aluResult),
		.signResult(signResult),
		.truncResult(truncResult),
		.scaleResult(scaleResult),
		.issue(uIssue.issuer)
	);

	latencyTimer uTimer (
		.clk(clk),
		.rst(rst),
		.load(timerLoad),
		.count(timerCount),
		.expired(expired)
	);

	// Datapath units run freely on the captured operands
	intAluUnit uAlu (.clk(clk), .rst(rst), .issue(uIssue.unit), .aluResult(aluResult));
	fpSignUnit uSign (.clk(clk), .rst(rst), .issue(uIssue.unit), .signResult(signResult));
	fpTruncUnit uTrunc (.clk(clk), .rst(rst), .issue(uIssue.unit), .truncResult(truncResult));
	fpScaleUnit uScale (.clk(clk), .rst(rst), .issue(uIssue.unit), .scaleResult(scaleResult));

endmodule

// ==== source/execSequencer.sv ====
// ======================================================================
// Execute sequencer: accepts and classifies an instruction, times the
// selected unit and holds its result until the consumer takes it
// ======================================================================
module execSequencer
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	input logic opValid,
	output logic opReady,
	input instrWord_t instr,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic [dataWidth-1:0] imm,
	input logic resultReady,
	output logic resultValid,
	output logic [dataWidth-1:0] result,
	output logic illegal,
	input logic expired,
	output logic timerLoad,
	output logic [timerWidth-1:0] timerCount,
	input logic [dataWidth-1:0] aluResult,
	input logic [dataWidth-1:0] signResult,
	input logic [dataWidth-1:0] truncResult,
	input logic [dataWidth-1:0] scaleResult,
	issueIf.issuer issue
);

	logic [1:0] state;
	unitSel_t selNext;
	unitSel_t selReg;
	logic badOpcode;
	logic pendIllegal;
	logic accept;
	logic [dataWidth-1:0] unitOut;

	assign opReady = (state == stIdle);
	assign resultValid = (state == stHold);
	assign accept = opValid && opReady;
	assign timerLoad = accept && (selNext != UNIT_NONE);

	// ==================================================================
	// Decode of the incoming word
	// ==================================================================
	always_comb begin
		selNext = UNIT_ALU;
		badOpcode = 1'b0;
		case (instr.alu.opcode)
			OP_ADD, OP_AND, OP_OR, OP_XOR, OP_SUBF, OP_MOV, OP_LOADA:
				selNext = UNIT_ALU;
			OP_FLT: begin
				case (instr.flt.func)
					FN_FABS, FN_FNEG, FN_SGNJ, FN_SGNJN, FN_SGNJX, FN_ISNAN, FN_FINITE:
						selNext = UNIT_SIGN;
					FN_FTRUNC: selNext = UNIT_TRUNC;
					FN_FSCALEB: selNext = UNIT_SCALE;
					default: selNext = UNIT_NONE;
				endcase
			end
			// Still runs through the ALU, which yields zero
			default: badOpcode = 1'b1;
		endcase
	end

	always_comb begin
		case (selNext)
			UNIT_SIGN: timerCount = latSign;
			UNIT_TRUNC: timerCount = latTrunc;
			UNIT_SCALE: timerCount = latScale;
			default: timerCount = latAlu;
		endcase
	end

	always_comb begin
		case (selReg)
			UNIT_ALU: unitOut = aluResult;
			UNIT_SIGN: unitOut = signResult;
			UNIT_TRUNC: unitOut = truncResult;
			UNIT_SCALE: unitOut = scaleResult;
			default: unitOut = '0;
		endcase
	end

	// ==================================================================
	// Control FSM
	// ==================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= stIdle;
			selReg <= UNIT_NONE;
			pendIllegal <= 1'b0;
			illegal <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (accept) begin
						selReg <= selNext;
						pendIllegal <= badOpcode;
						if (selNext == UNIT_NONE) begin
							state <= stHold;
							illegal <= 1'b1;
						end else begin
							state <= stBusy;
						end
					end
				end
				stBusy: begin
					if (expired) begin
						state <= stHold;
						illegal <= pendIllegal;
					end
				end
				stHold: begin
					if (resultReady) begin
						state <= stIdle;
						illegal <= 1'b0;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Result hold register
	always_ff @(posedge clk) begin
		if (accept && (selNext == UNIT_NONE))
			result <= '0;
		else if ((state == stBusy) && expired)
			result <= unitOut;
	end

	// Operands stay put until the next acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			issue.instr <= instr;
			issue.a <= a;
			issue.b <= b;
			issue.imm <= imm;
		end
	end

endmodule

// ==== source/fpScaleUnit.sv ====
// ======================================================================
// Three-stage quad-precision scale by a power of two, saturating to
// infinity or zero when the new exponent leaves the normal range
// ======================================================================
module fpScaleUnit
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	issueIf.unit issue,
	output logic [dataWidth-1:0] scaleResult
);

	// Stage one, a and the clamped shift
	logic [dataWidth-1:0] aS1;
	logic signed [expBits+1:0] shiftS1;
	// Stage two, a and the raw new exponent
	logic [dataWidth-1:0] aS2;
	logic signed [expBits+2:0] expS2;

	logic signed [expBits+1:0] shiftSat;
	logic [expBits-1:0] expOld;
	logic [dataWidth-1:0] scaleNext;

	// b is taken as a signed count
	always_comb begin
		if ($signed(issue.b) > scaleLimit)
			shiftSat = (expBits+2)'(scaleLimit);
		else if ($signed(issue.b) < -scaleLimit)
			shiftSat = -(expBits+2)'(scaleLimit);
		else
			shiftSat = issue.b[expBits+1:0];
	end

	assign expOld = aS2[dataWidth-2 -: expBits];

	always_comb begin
		if ((expOld == '0) || (&expOld))
			// Zero, denormal, infinity and NaN pass through
			scaleNext = aS2;
		else if (expS2 >= expMax)
			scaleNext = {aS2[dataWidth-1], {expBits{1'b1}}, {fracBits{1'b0}}};
		else if (expS2 <= 0)
			scaleNext = {aS2[dataWidth-1], {(dataWidth-1){1'b0}}};
		else
			scaleNext = {aS2[dataWidth-1], expS2[expBits-1:0], aS2[fracBits-1:0]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			aS1 <= '0;
			shiftS1 <= '0;
			aS2 <= '0;
			expS2 <= '0;
			scaleResult <= '0;
		end else begin
			aS1 <= issue.a;
			shiftS1 <= shiftSat;
			aS2 <= aS1;
			expS2 <= (expBits+3)'(aS1[dataWidth-2 -: expBits]) + (expBits+3)'(shiftS1);
			scaleResult <= scaleNext;
		end
	end

endmodule

// ==== source/fpTruncUnit.sv ====
// ======================================================================
// Two-stage quad-precision truncate toward zero
// ======================================================================
module fpTruncUnit
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	issueIf.unit issue,
	output logic [dataWidth-1:0] truncResult
);

	// Stage one holds a and its unbiased exponent
	logic [dataWidth-1:0] aS1;
	logic signed [expBits+1:0] expS1;

	logic [6:0] clrBits;
	logic [dataWidth-1:0] keepMask;
	logic [dataWidth-1:0] truncNext;

	// Fraction bits below the binary point, 1 to 112 in the middle range
	assign clrBits = 7'(fracBits) - expS1[6:0];
	assign keepMask = {dataWidth{1'b1}} << clrBits;

	always_comb begin
		if (expS1 < 0)
			truncNext = {aS1[dataWidth-1], {(dataWidth-1){1'b0}}};
		else if (expS1 >= fracBits)
			// Already integral, also covers infinity and NaN
			truncNext = aS1;
		else
			truncNext = aS1 & keepMask;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			aS1 <= '0;
			expS1 <= '0;
			truncResult <= '0;
		end else begin
			aS1 <= issue.a;
			expS1 <= (expBits+2)'(issue.a[dataWidth-2 -: expBits]) - (expBits+2)'(expBias);
			truncResult <= truncNext;
		end
	end

endmodule

// ==== source/fpSignUnit.sv ====
// ======================================================================
// Quad-precision sign manipulation and classification, registered
// ======================================================================
module fpSignUnit
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	issueIf.unit issue,
	output logic [dataWidth-1:0] signResult
);

	logic signA;
	logic signB;
	logic [expBits-1:0] expA;
	logic [fracBits-1:0] fracA;
	logic [dataWidth-2:0] magB;
	logic [dataWidth-1:0] signNext;

	assign signA = issue.a[dataWidth-1];
	assign signB = issue.b[dataWidth-1];
	assign expA = issue.a[dataWidth-2 -: expBits];
	assign fracA = issue.a[fracBits-1:0];
	assign magB = issue.b[dataWidth-2:0];

	always_comb begin
		case (issue.instr.flt.func)
			FN_FABS: signNext = {1'b0, issue.a[dataWidth-2:0]};
			FN_FNEG: signNext = {~signA, issue.a[dataWidth-2:0]};
			FN_SGNJ: signNext = {signA, magB};
			FN_SGNJN: signNext = {~signA, magB};
			FN_SGNJX: signNext = {signA ^ signB, magB};
			// Classification answers land in bit 0
			FN_ISNAN: signNext = dataWidth'((&expA) && (|fracA));
			FN_FINITE: signNext = dataWidth'(~&expA);
			default: signNext = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			signResult <= '0;
		else
			signResult <= signNext;
	end

endmodule

// ==== source/intAluUnit.sv ====
// ======================================================================
// Integer ALU: add, absolute sum, logic ops, reverse subtract, move
// and address generation, with a registered result
// ======================================================================
module intAluUnit
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	issueIf.unit issue,
	output logic [dataWidth-1:0] aluResult
);

	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] sum;
	logic [dataWidth-1:0] absSum;
	logic [dataWidth-1:0] addrGen;
	logic [dataWidth-1:0] aluNext;

	// Immediate replaces b when selected
	assign opB = issue.instr.alu.immSel ? issue.imm : issue.b;
	assign sum = issue.a + opB;
	assign absSum = sum[dataWidth-1] ? -sum : sum;

	// Scaled-index address
	assign addrGen = issue.a + issue.imm + (issue.b << issue.instr.alu.shAmt);

	always_comb begin
		aluNext = '0;
		case (issue.instr.alu.opcode)
			OP_ADD: begin
				case (issue.instr.alu.op3)
					3'd0: aluNext = sum;
					3'd2: aluNext = absSum;
					default: aluNext = '0;
				endcase
			end
			OP_AND: begin
				case (issue.instr.alu.op3)
					3'd0: aluNext = issue.a & opB;
					3'd1: aluNext = ~(issue.a & opB);
					3'd2: aluNext = issue.a & ~opB;
					default: aluNext = '0;
				endcase
			end
			OP_OR: begin
				case (issue.instr.alu.op3)
					3'd0: aluNext = issue.a | opB;
					3'd1: aluNext = ~(issue.a | opB);
					3'd2: aluNext = issue.a | ~opB;
					default: aluNext = '0;
				endcase
			end
			OP_XOR: begin
				case (issue.instr.alu.op3)
					3'd0: aluNext = issue.a ^ opB;
					3'd1: aluNext = ~(issue.a ^ opB);
					3'd2: aluNext = issue.a ^ ~opB;
					default: aluNext = '0;
				endcase
			end
			OP_SUBF: aluNext = opB - issue.a;
			OP_MOV: aluNext = issue.a;
			OP_LOADA: aluNext = addrGen;
			default: aluNext = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			aluResult <= '0;
		else
			aluResult <= aluNext;
	end

endmodule

// ==== source/latencyTimer.sv ====
// ======================================================================
// Loadable down-counter that flags when an operation's latency is up
// ======================================================================
module latencyTimer
	import fpuExecPkg::*;
(
	input logic clk,
	input logic rst,
	input logic load,
	input logic [timerWidth-1:0] count,
	output logic expired
);

	// Cycles left before expiry, zero when idle
	logic [timerWidth-1:0] remain;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			remain <= '0;
			expired <= 1'b0;
		end else begin
			// One-cycle pulse on the edge where the count runs out
			expired <= (remain == timerWidth'(1));
			if (load)
				remain <= count;
			else if (remain != '0)
				remain <= remain - 1'b1;
		end
	end

endmodule

// ==== source/issueIf.sv ====
// ======================================================================
// Issue bundle carrying the captured instruction and its operands
// ======================================================================
interface issueIf
	import fpuExecPkg::*;
();

	// Captured instruction word
	instrWord_t instr;

	// Operands and immediate
	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic [dataWidth-1:0] imm;

	// Sequencer side loads the bundle on acceptance
	modport issuer (
		output instr,
		output a,
		output b,
		output imm
	);

	// Datapath units only read it
	modport unit (
		input instr,
		input a,
		input b,
		input imm
	);

endinterface

// ==== source/fpuExecPkg.sv ====
// ======================================================================
// Shared definitions for the 128-bit execute unit: widths, encodings,
// the quad-precision layout, unit latencies and the instruction word
// ======================================================================
package fpuExecPkg;

	// Operand width and quad-precision layout
	localparam int dataWidth = 128;
	localparam int fracBits = 112;
	localparam int expBits = 15;
	localparam int expBias = 16383;
	localparam int expMax = 32767;
	// Largest shift magnitude that scale accepts from b
	localparam int scaleLimit = 32768;

	// Down-counter width and per-unit latency from issue to unit output
	localparam int timerWidth = 2;
	localparam logic [timerWidth-1:0] latAlu = 2'd1;
	localparam logic [timerWidth-1:0] latSign = 2'd1;
	localparam logic [timerWidth-1:0] latTrunc = 2'd2;
	localparam logic [timerWidth-1:0] latScale = 2'd3;

	// Sequencer state encoding
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stBusy = 2'd1;
	localparam logic [1:0] stHold = 2'd2;

	typedef enum logic [6:0] {
		OP_FLT = 7'h02,
		OP_ADD = 7'h04,
		OP_SUBF = 7'h05,
		OP_AND = 7'h08,
		OP_OR = 7'h09,
		OP_XOR = 7'h0A,
		OP_MOV = 7'h0C,
		OP_LOADA = 7'h0E
	} opcode_t;

	typedef enum logic [6:0] {
		FN_FABS = 7'h10,
		FN_FNEG = 7'h11,
		FN_ISNAN = 7'h12,
		FN_FINITE = 7'h13,
		FN_FTRUNC = 7'h14,
		FN_SGNJ = 7'h20,
		FN_SGNJN = 7'h21,
		FN_SGNJX = 7'h22,
		FN_FSCALEB = 7'h30
	} fltFunc_t;

	typedef enum logic [2:0] {
		UNIT_ALU = 3'd0,
		UNIT_SIGN = 3'd1,
		UNIT_TRUNC = 3'd2,
		UNIT_SCALE = 3'd3,
		UNIT_NONE = 3'd7
	} unitSel_t;

	// Integer format
	typedef struct packed {
		logic immSel;
		logic [6:0] rsvHigh;
		logic [1:0] shAmt;
		logic [11:0] rsvLow;
		logic [2:0] op3;
		opcode_t opcode;
	} aluInstr_t;

	// Float format
	typedef struct packed {
		fltFunc_t func;
		logic [17:0] rsv;
		opcode_t opcode;
	} fltInstr_t;

	// Same 32 bits seen either way, opcode lines up in both
	typedef union packed {
		aluInstr_t alu;
		fltInstr_t flt;
	} instrWord_t;

endpackage
